//--- build.f
+incdir+tests
logic/bus_pkg.sv
logic/parallel_bus_slave.sv
logic/gearbox_ram.sv
logic/playback_streamer.sv
logic/bus_memory_top.sv
tests/tb_bus_memory.sv

//--- logic/bus_memory_top.sv
/*
 host-loaded playback memory. single clock, reset125 synchronous and active high
*/
module bus_memory_top #(
	parameter int ADDR_WIDTH = 14,
	parameter int SYNC_DEPTH = 10,
	parameter int ACK_DELAY = 20,
	parameter int AUTOINCREMENT = 1,
	parameter int PLAYBACK_BYTES = 16384
) (
	input logic clock,
	input logic reset125,
	inout wire bus_pkg::halfword_t bus,
	input logic read,
	input logic register_select,
	input logic enable,
	output logic ack_valid,
	input logic sync_in,
	output bus_pkg::byte_t stream_byte,
	output logic stream_start
);
	logic [ADDR_WIDTH-1:0] mem_address;
	bus_pkg::word_u write_word;
	bus_pkg::word_u read_word;
	logic write_strobe;
	logic [ADDR_WIDTH+1:0] byte_address;

	// ------------------------------------------------------------
	// producer, buffer, consumer
	// ------------------------------------------------------------
	parallel_bus_slave #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.SYNC_DEPTH(SYNC_DEPTH),
		.ACK_DELAY(ACK_DELAY),
		.AUTOINCREMENT(AUTOINCREMENT)
	) slave (
		.clock(clock), .reset125(reset125), .bus(bus), .read(read),
		.register_select(register_select), .enable(enable), .ack_valid(ack_valid),
		.mem_address(mem_address), .write_word(write_word),
		.write_strobe(write_strobe), .read_word(read_word)
	);

	gearbox_ram #(.ADDR_WIDTH(ADDR_WIDTH)) ram (
		.clock(clock), .mem_address(mem_address), .write_word(write_word),
		.write_strobe(write_strobe), .read_word(read_word),
		.byte_address(byte_address), .stream_byte(stream_byte)
	);

	playback_streamer #(.PLAYBACK_BYTES(PLAYBACK_BYTES), .ADDR_WIDTH(ADDR_WIDTH)) streamer (
		.clock(clock), .reset125(reset125), .sync_in(sync_in),
		.byte_address(byte_address), .stream_start(stream_start)
	);

endmodule

//--- logic/bus_pkg.sv
/*
 shared bus and playback widths. a data word is HALVES_PER_WORD bus transfers,
 most significant halfword first on the bus
*/
package bus_pkg;

	// ------------------------------------------------------------
	// widths
	// ------------------------------------------------------------
	localparam int HALF_WIDTH = 16; // host bus
	localparam int HALVES_PER_WORD = 2;
	localparam int WORD_WIDTH = HALF_WIDTH * HALVES_PER_WORD;
	localparam int BYTE_WIDTH = 8; // playback sample
	localparam int BYTES_PER_WORD = WORD_WIDTH / BYTE_WIDTH;

	// ------------------------------------------------------------
	// types
	// ------------------------------------------------------------
	typedef logic [HALF_WIDTH-1:0] halfword_t;

	typedef logic [BYTE_WIDTH-1:0] byte_t;

	// one memory word, seen whole by the memory port
	// or as bus transfers by the slave; half[1] is the upper halfword
	typedef union packed {
		logic [WORD_WIDTH-1:0] full;
		halfword_t [HALVES_PER_WORD-1:0] half;
	} word_u;

endpackage

//--- logic/gearbox_ram.sv
/*
 dual-port word memory with a byte-wide read port. both ports have one cycle of
 read latency; port A reads the old word on a write to the same address
*/
module gearbox_ram #(
	parameter int ADDR_WIDTH = 14
) (
	input logic clock,
	// port A on the bus side
	input logic [ADDR_WIDTH-1:0] mem_address,
	input bus_pkg::word_u write_word,
	input logic write_strobe,
	output bus_pkg::word_u read_word,
	// port B on the playback side
	input logic [ADDR_WIDTH+1:0] byte_address,
	output bus_pkg::byte_t stream_byte
);
	localparam int DEPTH = 2 ** ADDR_WIDTH;
	localparam int LANE_BITS = $clog2(bus_pkg::BYTES_PER_WORD);

	bus_pkg::word_u mem [DEPTH];

	// ------------------------------------------------------------
	// port A
	// ------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (write_strobe) begin
			mem[mem_address] <= write_word;
		end
		read_word <= mem[mem_address];
	end

	// ------------------------------------------------------------
	// port B
	// ------------------------------------------------------------
	bus_pkg::word_u word_b;
	logic [LANE_BITS-1:0] lane_q; // lane of the word in word_b

	always_ff @(posedge clock) begin
		word_b <= mem[byte_address[ADDR_WIDTH+LANE_BITS-1:LANE_BITS]];
		lane_q <= byte_address[LANE_BITS-1:0];
	end

	// lane 0 is the least significant byte
	assign stream_byte = word_b.full[lane_q*bus_pkg::BYTE_WIDTH +: bus_pkg::BYTE_WIDTH];

endmodule

//--- logic/parallel_bus_slave.sv
/*
 host bus slave. needs SYNC_DEPTH >= 2 and ACK_DELAY >= 1. the host paces every
 transfer, there is no back-pressure. bus is driven whenever read is high
*/
module parallel_bus_slave #(
	parameter int ADDR_WIDTH = 14,
	parameter int SYNC_DEPTH = 10,
	parameter int ACK_DELAY = 20,
	parameter int AUTOINCREMENT = 1
) (
	input logic clock,
	input logic reset125,
	inout wire bus_pkg::halfword_t bus,
	input logic read, // 0=write, 1=read
	input logic register_select, // 0=address, 1=data
	input logic enable,
	output logic ack_valid,
	output logic [ADDR_WIDTH-1:0] mem_address,
	output bus_pkg::word_u write_word,
	output logic write_strobe,
	input bus_pkg::word_u read_word
);
	localparam int COUNT_WIDTH = $clog2(bus_pkg::HALVES_PER_WORD);
	localparam logic [COUNT_WIDTH-1:0] FIRST_HALF = COUNT_WIDTH'(bus_pkg::HALVES_PER_WORD - 1);
	localparam int SEL_READ = 2; // bit positions in the control pipeline
	localparam int SEL_RS = 1;
	localparam int SEL_ENABLE = 0;

	// ------------------------------------------------------------
	// sampling pipelines
	// ------------------------------------------------------------
	logic [SYNC_DEPTH-1:0][2:0] ctrl_pipe;
	bus_pkg::halfword_t [SYNC_DEPTH-1:0] bus_pipe;
	logic [2:0] ctrl_high; // last two samples both high
	logic [2:0] ctrl_low;
	logic en_high, en_low;
	logic read_mode, write_mode, addr_mode;

	always_ff @(posedge clock) begin
		if (reset125) begin
			ctrl_pipe <= '0;
		end else begin
			ctrl_pipe <= {ctrl_pipe[SYNC_DEPTH-2:0], {read, register_select, enable}};
		end
	end

	always_ff @(posedge clock) begin
		bus_pipe <= {bus_pipe[SYNC_DEPTH-2:0], bus};
	end

	assign ctrl_high = ctrl_pipe[SYNC_DEPTH-1] & ctrl_pipe[SYNC_DEPTH-2];
	assign ctrl_low = ~(ctrl_pipe[SYNC_DEPTH-1] | ctrl_pipe[SYNC_DEPTH-2]);
	assign en_high = ctrl_high[SEL_ENABLE];
	assign en_low = ctrl_low[SEL_ENABLE];
	assign read_mode = ctrl_high[SEL_READ];
	assign write_mode = ctrl_low[SEL_READ] & ctrl_high[SEL_RS];
	assign addr_mode = ctrl_low[SEL_READ] & ctrl_low[SEL_RS];

	// ------------------------------------------------------------
	// transaction state machines
	// ------------------------------------------------------------
	logic a_taken, a_done; // address
	logic w_taken, w_done; // write
	logic r_taken, r_done; // read
	logic [COUNT_WIDTH-1:0] w_count, r_count;
	bus_pkg::halfword_t a_half; // address halfword as received
	bus_pkg::halfword_t out_half;
	logic pre_ack;

	always_ff @(posedge clock) begin
		if (reset125) begin
			pre_ack <= 1'b0;
			write_strobe <= 1'b0;
			a_taken <= 1'b0;
			a_done <= 1'b0;
			w_taken <= 1'b0;
			w_done <= 1'b0;
			w_count <= FIRST_HALF;
			r_taken <= 1'b0;
			r_done <= 1'b0;
			r_count <= FIRST_HALF;
			mem_address <= '0;
		end else begin
			pre_ack <= 1'b0;
			write_strobe <= 1'b0;
			if (en_high) begin
				if (read_mode) begin
					pre_ack <= 1'b1;
					if (!r_taken && !r_done) begin // once per enable
						r_taken <= 1'b1;
						out_half <= read_word.half[r_count];
					end
				end else if (write_mode) begin
					pre_ack <= 1'b1;
					if (!w_taken && !w_done) begin
						w_taken <= 1'b1;
						write_word.half[w_count] <= bus_pipe[SYNC_DEPTH-1];
					end
				end else if (addr_mode) begin
					pre_ack <= 1'b1;
					if (!a_taken && !a_done) begin
						a_taken <= 1'b1;
						a_half <= bus_pipe[SYNC_DEPTH-1];
					end
				end
			end else if (en_low) begin
				if (AUTOINCREMENT != 0 && (r_done || w_done)) begin
					mem_address <= mem_address + 1'b1; // one cycle after the strobe
				end
				if (w_taken || w_done) begin
					r_taken <= 1'b0; // drop other partial progress
					r_done <= 1'b0;
					r_count <= FIRST_HALF;
					a_taken <= 1'b0;
					a_done <= 1'b0;
					if (w_done) begin
						w_done <= 1'b0;
						w_count <= FIRST_HALF;
					end else begin
						w_taken <= 1'b0;
						if (w_count != '0) begin
							w_count <= w_count - 1'b1;
						end else begin
							w_done <= 1'b1;
							write_strobe <= 1'b1;
						end
					end
				end
				if (r_taken || r_done) begin
					w_taken <= 1'b0;
					w_done <= 1'b0;
					w_count <= FIRST_HALF;
					a_taken <= 1'b0;
					a_done <= 1'b0;
					if (r_done) begin
						r_done <= 1'b0;
						r_count <= FIRST_HALF;
					end else begin
						r_taken <= 1'b0;
						if (r_count != '0) begin
							r_count <= r_count - 1'b1;
						end else begin
							r_done <= 1'b1;
						end
					end
				end
				if (a_taken || a_done) begin
					w_taken <= 1'b0;
					w_done <= 1'b0;
					w_count <= FIRST_HALF;
					r_taken <= 1'b0;
					r_done <= 1'b0;
					r_count <= FIRST_HALF;
					if (a_done) begin
						a_done <= 1'b0;
						mem_address <= a_half[ADDR_WIDTH-1:0]; // wins over increment
					end else begin
						a_taken <= 1'b0;
						a_done <= 1'b1; // address is a single halfword
					end
				end
			end
		end
	end

	// ------------------------------------------------------------
	// acknowledge and bus drive
	// ------------------------------------------------------------
	logic [ACK_DELAY:0] ack_pipe;

	always_ff @(posedge clock) begin
		if (reset125) begin
			ack_pipe <= '0;
		end else begin
			ack_pipe <= {ack_pipe[ACK_DELAY-1:0], pre_ack};
		end
	end

	assign ack_valid = ack_pipe[ACK_DELAY];
	assign bus = read ? out_half : {bus_pkg::HALF_WIDTH{1'bz}};

endmodule

//--- logic/playback_streamer.sv
/*
 cyclic byte address generator. PLAYBACK_BYTES must fit in ADDR_WIDTH+2 bits.
 stream_start lines up with the memory's one-cycle read latency
*/
module playback_streamer #(
	parameter int PLAYBACK_BYTES = 16384,
	parameter int ADDR_WIDTH = 14
) (
	input logic clock,
	input logic reset125,
	input logic sync_in, // restart request
	output logic [ADDR_WIDTH+1:0] byte_address,
	output logic stream_start
);
	localparam logic [ADDR_WIDTH+1:0] LAST_BYTE = (ADDR_WIDTH + 2)'(PLAYBACK_BYTES - 1);

	logic sync_q;
	logic wrap;

	// ------------------------------------------------------------
	// address counter
	// ------------------------------------------------------------
	assign wrap = sync_q || (byte_address == LAST_BYTE);

	always_ff @(posedge clock) begin
		if (reset125) begin
			sync_q <= 1'b0;
			byte_address <= '0; // held at frame start
		end else begin
			sync_q <= sync_in;
			if (wrap) begin
				byte_address <= '0;
			end else begin
				byte_address <= byte_address + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// frame start marker
	// ------------------------------------------------------------
	// byte 0 leaves the memory one cycle after its address
	always_ff @(posedge clock) begin
		if (reset125) begin
			stream_start <= 1'b0;
		end else begin
			stream_start <= (byte_address == '0);
		end
	end

endmodule

//--- tests/bus_host_tasks.svh
/*
 host side of the parallel bus handshake. included inside the testbench module,
 uses its clock, bus lines, error counters, SYNC_DEPTH and ACK_LIMIT
*/
`ifndef BUS_HOST_TASKS_SVH
`define BUS_HOST_TASKS_SVH

// ------------------------------------------------------------
// drive one transfer, wait for ack, then release and wait for ack low
// ------------------------------------------------------------
task automatic run_transfer(input logic rd, input logic rs, input bus_pkg::halfword_t value,
		output bus_pkg::halfword_t seen);
	int cycles;
	enable_seen = 1'b1;
	@(posedge clock);
	read <= rd;
	register_select <= rs;
	host_bus <= value;
	enable <= 1'b1;
	cycles = 0;
	while (ack_valid !== 1'b1 && cycles <= ACK_LIMIT) begin
		@(negedge clock); // sample away from the driving edge
		cycles++;
	end
	if (ack_valid !== 1'b1) begin
		timeout_errors++;
		$display("timeout at %0t: ack_valid did not rise within %0d cycles of enable",
			$time, ACK_LIMIT);
	end
	assert (cycles > SYNC_DEPTH) else begin
		value_errors++;
		$display("at %0t ack_valid rose %0d cycles after enable, sooner than %0d cycles",
			$time, cycles - 1, SYNC_DEPTH);
	end
	seen = bus;
	@(posedge clock);
	enable <= 1'b0;
	cycles = 0;
	while (ack_valid !== 1'b0 && cycles <= ACK_LIMIT) begin
		@(negedge clock);
		cycles++;
	end
	if (ack_valid !== 1'b0) begin
		timeout_errors++;
		$display("timeout at %0t: ack_valid did not fall within %0d cycles of enable low",
			$time, ACK_LIMIT);
	end
	assert (cycles > SYNC_DEPTH) else begin
		value_errors++;
		$display("at %0t ack_valid fell %0d cycles after enable low, sooner than %0d cycles",
			$time, cycles - 1, SYNC_DEPTH);
	end
endtask

task automatic set_address(input bus_pkg::halfword_t address);
	bus_pkg::halfword_t unused;
	run_transfer(1'b0, 1'b0, address, unused);
endtask

// most significant halfword first
task automatic write_data(input logic [bus_pkg::WORD_WIDTH-1:0] word);
	bus_pkg::halfword_t unused;
	run_transfer(1'b0, 1'b1, word[bus_pkg::WORD_WIDTH-1 -: bus_pkg::HALF_WIDTH], unused);
	run_transfer(1'b0, 1'b1, word[bus_pkg::HALF_WIDTH-1:0], unused);
endtask

task automatic read_data(input logic [bus_pkg::WORD_WIDTH-1:0] expected);
	bus_pkg::halfword_t upper;
	bus_pkg::halfword_t lower;
	run_transfer(1'b1, 1'b1, '0, upper);
	run_transfer(1'b1, 1'b1, '0, lower);
	assert ({upper, lower} === expected) else begin
		value_errors++;
		$display("ERR %0t bus expected %h actual %h", $time, expected, {upper, lower});
	end
endtask

`endif

//--- tests/tb_bus_memory.sv
/*
 testbench for bus_memory_top with a small memory and short frames.
 only words 0 to 7 are written, so only they are streamed and read back
*/
module tb_bus_memory;

	localparam int ADDR_WIDTH = 6;
	localparam int SYNC_DEPTH = 4;
	localparam int ACK_DELAY = 3;
	localparam int PLAYBACK_BYTES = 32;
	localparam int ACK_LIMIT = SYNC_DEPTH + ACK_DELAY + 3;
	localparam int FRAME_WORDS = PLAYBACK_BYTES / bus_pkg::BYTES_PER_WORD;

	logic clock = 1'b0;
	logic reset125;
	logic read;
	logic register_select;
	logic enable;
	logic sync_in;
	logic ack_valid;
	logic stream_start;
	bus_pkg::byte_t stream_byte;
	bus_pkg::halfword_t host_bus;
	wire bus_pkg::halfword_t bus;

	int value_errors = 0;
	int timeout_errors = 0;
	logic enable_seen = 1'b0;
	integer seed;
	logic [bus_pkg::WORD_WIDTH-1:0] model [2 ** ADDR_WIDTH]; // expected memory contents

	always #4 clock = ~clock;

	assign bus = read ? {bus_pkg::HALF_WIDTH{1'bz}} : host_bus; // host drives only for writes

	bus_memory_top #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.SYNC_DEPTH(SYNC_DEPTH),
		.ACK_DELAY(ACK_DELAY),
		.AUTOINCREMENT(1),
		.PLAYBACK_BYTES(PLAYBACK_BYTES)
	) DUT (
		.clock(clock), .reset125(reset125), .bus(bus), .read(read),
		.register_select(register_select), .enable(enable), .ack_valid(ack_valid),
		.sync_in(sync_in), .stream_byte(stream_byte), .stream_start(stream_start)
	);

	`include "bus_host_tasks.svh"

	// ------------------------------------------------------------
	// idle checks until the first transfer
	// ------------------------------------------------------------
	always @(negedge clock) begin
		if (!enable_seen) begin
			assert (ack_valid === 1'b0) else begin
				value_errors++;
				$display("ERR %0t ack_valid expected 0 actual %b", $time, ack_valid);
			end
			assert (bus === host_bus) else begin
				value_errors++;
				$display("ERR %0t bus expected %h actual %h", $time, host_bus, bus);
			end
		end
	end

	// ------------------------------------------------------------
	// playback checks
	// ------------------------------------------------------------
	function automatic bus_pkg::byte_t model_byte(input int index);
		logic [bus_pkg::WORD_WIDTH-1:0] word;
		word = model[index / bus_pkg::BYTES_PER_WORD];
		return word[(index % bus_pkg::BYTES_PER_WORD) * bus_pkg::BYTE_WIDTH +: bus_pkg::BYTE_WIDTH];
	endfunction

	task automatic wait_stream_start();
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (stream_start !== 1'b1 && cycles < 2 * PLAYBACK_BYTES) begin
			@(negedge clock);
			cycles++;
		end
		if (stream_start !== 1'b1) begin
			timeout_errors++;
			$display("timeout at %0t: no stream_start pulse within two frames", $time);
		end
	endtask

	// called at the negedge where stream_start should be high
	task automatic check_frame();
		int i;
		for (i = 0; i < PLAYBACK_BYTES; i++) begin
			assert (stream_start === (i == 0)) else begin
				value_errors++;
				$display("ERR %0t stream_start expected %b actual %b", $time, (i == 0),
					stream_start);
			end
			assert (stream_byte === model_byte(i)) else begin
				value_errors++;
				$display("ERR %0t stream_byte expected %h actual %h", $time, model_byte(i),
					stream_byte);
			end
			@(negedge clock);
		end
		assert (stream_start === 1'b1) else begin // next frame starts exactly one frame later
			value_errors++;
			$display("ERR %0t stream_start expected 1 actual %b", $time, stream_start);
		end
	endtask

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	initial begin
		logic [bus_pkg::WORD_WIDTH-1:0] word_value;
		int i;
		seed = 32'h6e49;
		reset125 <= 1'b1;
		read <= 1'b0;
		register_select <= 1'b0;
		enable <= 1'b0;
		sync_in <= 1'b0;
		host_bus <= 16'h5a3c; // visible on bus while read is low
		repeat (16) @(posedge clock);
		reset125 <= 1'b0;
		repeat (4) @(posedge clock);

		// fill words 0..7 through autoincrement, then read them back
		set_address(16'h0000);
		for (i = 0; i < FRAME_WORDS; i++) begin
			word_value = $random(seed);
			model[i] = word_value;
			write_data(word_value);
		end
		set_address(16'h0000);
		for (i = 0; i < FRAME_WORDS; i++) begin
			read_data(model[i]);
		end

		// overwrite one word and read back its neighbours
		word_value = $random(seed);
		model[5] = word_value;
		set_address(16'h0005);
		write_data(word_value);
		set_address(16'h0005);
		read_data(model[5]);
		set_address(16'h0004);
		for (i = 4; i < 7; i++) begin
			read_data(model[i]);
		end

		// two free running frames
		wait_stream_start();
		check_frame();
		check_frame();

		// restart mid-frame
		repeat (10) @(negedge clock);
		@(posedge clock);
		sync_in <= 1'b1;
		@(posedge clock);
		sync_in <= 1'b0; // sampled high at this edge
		repeat (2) begin
			@(negedge clock);
			assert (stream_start === 1'b0) else begin
				value_errors++;
				$display("ERR %0t stream_start expected 0 actual %b", $time, stream_start);
			end
		end
		@(negedge clock);
		check_frame();

		$display("value errors %0d, timeout errors %0d", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule
